/* frontend_pkg.sv */
/*
 * Front-end control package with widths, register and state encodings,
 * and the packed structs shared by the settings, channel and pin blocks
 */
`default_nettype none

package frontend_pkg;

   // ----------------------------------------------------------
   // Sizes
   // ----------------------------------------------------------
   localparam int NUM_CHANNELS   = 2;    // Radio channels on the board
   localparam int SAMPLE_W       = 12;   // I or Q sample width
   localparam int WORD_W         = 32;   // Packed sample word and settings data
   localparam int SET_ADDR_W     = 8;    // Settings address width
   localparam int HOLDOFF_CYCLES = 64;   // Locked cycles before bus comes up
   localparam int HOLDOFF_W      = $clog2(HOLDOFF_CYCLES);

   // ----------------------------------------------------------
   // Encodings
   // ----------------------------------------------------------
   // Low address nibble of a settings write
   typedef enum logic [3:0] {
      ATR_IDLE   = 4'h0,
      ATR_RX     = 4'h1,
      ATR_TX     = 4'h2,
      ATR_FDX    = 4'h3,
      MISC_OUTS  = 4'h4,
      RADIO_CTRL = 4'h5
   } set_reg_e;

   // Radio state, selects one ATR word
   typedef enum logic [1:0] {
      IDLE        = 2'd0,
      RX_ONLY     = 2'd1,
      TX_ONLY     = 2'd2,
      FULL_DUPLEX = 2'd3
   } atr_state_e;

   // ----------------------------------------------------------
   // Buses
   // ----------------------------------------------------------
   typedef struct packed {
      logic                  stb;   // One write per high cycle
      logic [SET_ADDR_W-1:0] addr;  // Upper nibble target, lower nibble register
      logic [WORD_W-1:0]     data;
   } set_bus_t;

   typedef struct packed {
      logic       stb;
      set_reg_e   reg_sel;
      logic [7:0] data;             // Low byte of the settings data
   } chan_wr_t;

   typedef struct packed {
      logic tx_enable;
      logic sfdx_rx;
      logic sfdx_tx;
      logic srx_rx;
      logic srx_tx;
      logic led_rx;
      logic led_txrx_rx;
      logic led_txrx_tx;
   } fe_pins_t;

   typedef struct packed {
      logic tx_bandsel_a;
      logic tx_bandsel_b;
      logic rx_bandsel_a;
      logic rx_bandsel_b;
      logic rx_bandsel_c;
      logic ref_sel;                // Reference clock source
   } misc_pins_t;

   typedef struct packed {
      logic codec_arst;             // Codec interface reset
      logic mimo;                   // Two-channel mode
   } radio_ctrl_t;

   typedef struct packed {
      logic [SAMPLE_W-1:0] i;
      logic [SAMPLE_W-1:0] q;
   } iq_sample_t;

endpackage

`default_nettype wire

/* reset_holdoff.sv */
/*
 * Clocks-ready hold-off. Waits for a run of PLL-locked cycles,
 * then releases the bus reset through a two-stage synchronizer
 */
`default_nettype none

module reset_holdoff (
   input  logic bus_clk,
   input  logic reset_global,
   input  logic pll_locked,
   output logic bus_rst
);
   import frontend_pkg::*;

   logic [HOLDOFF_W-1:0] lock_cnt;    // Consecutive locked cycles
   logic                 ready;       // Sticky until reset or lock loss
   logic [1:0]           rst_sync;

   // ----------------------------------------------------------
   // Hold-off counter
   // ----------------------------------------------------------
   // Lock loss clears at once, no clock needed
   always_ff @(posedge bus_clk or posedge reset_global or negedge pll_locked) begin
      if (reset_global || !pll_locked) begin
         lock_cnt <= '0;
         ready    <= 1'b0;
      end else if (!ready) begin
         lock_cnt <= lock_cnt + 1'b1;
         ready    <= (lock_cnt == HOLDOFF_W'(HOLDOFF_CYCLES - 1));  // Last count
      end
   end

   // Reset release two clocks after ready
   always_ff @(posedge bus_clk or posedge reset_global) begin
      if (reset_global) begin
         rst_sync <= 2'b11;
      end else begin
         rst_sync <= {rst_sync[0], ~ready};
      end
   end

   assign bus_rst = rst_sync[1];

endmodule

`default_nettype wire

/* settings_decoder.sv */
/*
 * Settings bus decoder. Splits each write into a per-channel register
 * write or a load of the global misc and radio control registers
 */
`default_nettype none

module settings_decoder (
   input  logic                      bus_clk,
   input  logic                      bus_rst,
   input  frontend_pkg::set_bus_t    set_in,
   output frontend_pkg::chan_wr_t    chan_wr [frontend_pkg::NUM_CHANNELS],
   output frontend_pkg::misc_pins_t  misc,
   output frontend_pkg::radio_ctrl_t radio_ctrl
);
   import frontend_pkg::*;

   logic [SET_ADDR_W-5:0] target;     // 0 global, 1+c channel c
   set_reg_e              reg_sel;
   logic [NUM_CHANNELS:0] wr_stb;     // Bit 0 global, bit c+1 channel c
   set_reg_e              wr_sel;
   logic [7:0]            wr_data;

   assign target  = set_in.addr[SET_ADDR_W-1:4];
   assign reg_sel = set_reg_e'(set_in.addr[3:0]);

   // ----------------------------------------------------------
   // Write strobe per target
   // ----------------------------------------------------------
   // Targets past the last channel match no bit
   always_ff @(posedge bus_clk or posedge bus_rst) begin
      if (bus_rst) begin
         wr_stb <= '0;
      end else begin
         for (int t = 0; t <= NUM_CHANNELS; t++) begin
            wr_stb[t] <= set_in.stb && (target == (SET_ADDR_W - 4)'(t));
         end
      end
   end

   // Register select and low data byte, shared by every target
   always_ff @(posedge bus_clk) begin
      if (set_in.stb) begin
         wr_sel  <= reg_sel;
         wr_data <= set_in.data[7:0];
      end
   end

   for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_chan_wr
      assign chan_wr[c] = '{stb: wr_stb[c + 1], reg_sel: wr_sel, data: wr_data};
   end

   // ----------------------------------------------------------
   // Global control registers
   // ----------------------------------------------------------
   always_ff @(posedge bus_clk or posedge bus_rst) begin
      if (bus_rst) begin
         misc       <= '0;
         radio_ctrl <= '0;
      end else if (wr_stb[0]) begin
         case (wr_sel)
            MISC_OUTS:  misc       <= misc_pins_t'(wr_data[5:0]);
            RADIO_CTRL: radio_ctrl <= radio_ctrl_t'(wr_data[1:0]);
            default:    ;                         // ATR slots unused globally
         endcase
      end
   end

endmodule

`default_nettype wire

/* fe_channel.sv */
/*
 * One radio channel front end. Holds the ATR words, drives the switch and
 * LED pins for the current radio state and packs RX samples into words
 */
`default_nettype none

module fe_channel (
   input  logic                            bus_clk,
   input  logic                            bus_rst,
   input  frontend_pkg::chan_wr_t          chan_wr,
   input  logic                            run_rx,
   input  logic                            run_tx,
   input  logic                            rx_stb,
   input  frontend_pkg::iq_sample_t        rx_in,
   output frontend_pkg::fe_pins_t          fe_pins,
   output logic [frontend_pkg::WORD_W-1:0] rx_word,
   output logic                            rx_word_stb
);
   import frontend_pkg::*;

   fe_pins_t   atr_word [4];          // One pin word per radio state
   atr_state_e state;

   // ----------------------------------------------------------
   // ATR register bank
   // ----------------------------------------------------------
   always_ff @(posedge bus_clk or posedge bus_rst) begin
      if (bus_rst) begin
         atr_word <= '{default: '0};
      end else if (chan_wr.stb) begin
         case (chan_wr.reg_sel)
            ATR_IDLE: atr_word[IDLE]        <= fe_pins_t'(chan_wr.data);
            ATR_RX:   atr_word[RX_ONLY]     <= fe_pins_t'(chan_wr.data);
            ATR_TX:   atr_word[TX_ONLY]     <= fe_pins_t'(chan_wr.data);
            ATR_FDX:  atr_word[FULL_DUPLEX] <= fe_pins_t'(chan_wr.data);
            default:  ;                         // Global registers live elsewhere
         endcase
      end
   end

   // Radio state from the run flags
   always_comb begin
      case ({run_tx, run_rx})
         2'b01:   state = RX_ONLY;
         2'b10:   state = TX_ONLY;
         2'b11:   state = FULL_DUPLEX;
         default: state = IDLE;
      endcase
   end

   always_ff @(posedge bus_clk or posedge bus_rst) begin
      if (bus_rst) begin
         fe_pins <= '0;
      end else begin
         fe_pins <= atr_word[state];            // One cycle after a run change
      end
   end

   // ----------------------------------------------------------
   // RX sample packing
   // ----------------------------------------------------------
   always_ff @(posedge bus_clk or posedge bus_rst) begin
      if (bus_rst) begin
         rx_word_stb <= 1'b0;
      end else begin
         rx_word_stb <= rx_stb;
      end
   end

   // I in the top half, Q in the bottom, low nibble of each zero
   always_ff @(posedge bus_clk) begin
      if (rx_stb) begin
         rx_word <= {rx_in.i, 4'h0, rx_in.q, 4'h0};
      end
   end

endmodule

`default_nettype wire

/* fe_pin_map.sv */
/*
 * Board pin stage. Registers the front-end and misc pins next to the pads
 * and captures a debug word from the raw RX samples
 */
`default_nettype none

module fe_pin_map (
   input  logic                     bus_clk,
   input  logic                     bus_rst,
   input  frontend_pkg::fe_pins_t   fe_in [frontend_pkg::NUM_CHANNELS],
   input  frontend_pkg::misc_pins_t misc_in,
   input  logic                     dbg_stb,
   input  frontend_pkg::iq_sample_t dbg_s0,
   input  frontend_pkg::iq_sample_t dbg_s1,
   output frontend_pkg::fe_pins_t   fe_pins [frontend_pkg::NUM_CHANNELS],
   output frontend_pkg::misc_pins_t misc_pins,
   output logic [31:0]              debug_bus
);
   import frontend_pkg::*;

   // ----------------------------------------------------------
   // Output pin registers
   // ----------------------------------------------------------
   // Flop next to the pads, keeps routing short
   always_ff @(posedge bus_clk or posedge bus_rst) begin
      if (bus_rst) begin
         for (int c = 0; c < NUM_CHANNELS; c++) begin
            fe_pins[c] <= '0;
         end
         misc_pins <= '0;
      end else begin
         for (int c = 0; c < NUM_CHANNELS; c++) begin
            fe_pins[c] <= fe_in[c];
         end
         misc_pins <= misc_in;                  // Band selects and ref select
      end
   end

   // ----------------------------------------------------------
   // Debug bus
   // ----------------------------------------------------------
   // Channel 1 I top byte, then channel 0 Q and I
   always_ff @(posedge bus_clk or posedge bus_rst) begin
      if (bus_rst) begin
         debug_bus <= '0;
      end else if (dbg_stb) begin
         debug_bus <= {dbg_s1.i[SAMPLE_W-1:SAMPLE_W-8], dbg_s0.q, dbg_s0.i};
      end
   end

endmodule

`default_nettype wire

/* frontend_ctrl_top.sv */
/*
 * Front-end control top level. Bus reset hold-off, settings decode,
 * per-channel front ends and the board pin stage
 */
`default_nettype none

module frontend_ctrl_top (
   input  logic                                bus_clk,
   input  logic                                reset_global,
   input  logic                                pll_locked,
   input  frontend_pkg::set_bus_t              set_in,
   input  logic [frontend_pkg::NUM_CHANNELS-1:0] run_rx,
   input  logic [frontend_pkg::NUM_CHANNELS-1:0] run_tx,
   input  logic [frontend_pkg::NUM_CHANNELS-1:0] rx_stb,
   input  frontend_pkg::iq_sample_t            rx_in [frontend_pkg::NUM_CHANNELS],
   output logic                                bus_ready,
   output frontend_pkg::fe_pins_t              fe_pins [frontend_pkg::NUM_CHANNELS],
   output frontend_pkg::misc_pins_t            misc_pins,
   output logic                                codec_arst,
   output logic                                mimo,
   output logic [frontend_pkg::WORD_W-1:0]     rx_word [frontend_pkg::NUM_CHANNELS],
   output logic [frontend_pkg::NUM_CHANNELS-1:0] rx_word_stb,
   output logic [31:0]                         debug_bus
);
   import frontend_pkg::*;

   logic        bus_rst;
   chan_wr_t    chan_wr [NUM_CHANNELS];
   misc_pins_t  misc;
   radio_ctrl_t radio_ctrl;
   fe_pins_t    fe_raw [NUM_CHANNELS];     // Channel pins before the pad flops

   assign bus_ready  = ~bus_rst;
   assign codec_arst = radio_ctrl.codec_arst;
   assign mimo       = radio_ctrl.mimo;

   // ----------------------------------------------------------
   // Reset and settings
   // ----------------------------------------------------------
   reset_holdoff reset_holdoff_i (
      .bus_clk      (bus_clk),
      .reset_global (reset_global),
      .pll_locked   (pll_locked),
      .bus_rst      (bus_rst)
   );

   settings_decoder settings_decoder_i (
      .bus_clk    (bus_clk),
      .bus_rst    (bus_rst),
      .set_in     (set_in),
      .chan_wr    (chan_wr),
      .misc       (misc),
      .radio_ctrl (radio_ctrl)
   );

   // ----------------------------------------------------------
   // Channels and pins
   // ----------------------------------------------------------
   for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_chan
      fe_channel fe_channel_i (
         .bus_clk     (bus_clk),
         .bus_rst     (bus_rst),
         .chan_wr     (chan_wr[c]),
         .run_rx      (run_rx[c]),
         .run_tx      (run_tx[c]),
         .rx_stb      (rx_stb[c]),
         .rx_in       (rx_in[c]),
         .fe_pins     (fe_raw[c]),
         .rx_word     (rx_word[c]),
         .rx_word_stb (rx_word_stb[c])
      );
   end

   fe_pin_map fe_pin_map_i (
      .bus_clk   (bus_clk),
      .bus_rst   (bus_rst),
      .fe_in     (fe_raw),
      .misc_in   (misc),
      .dbg_stb   (rx_stb[0]),           // Debug follows channel 0
      .dbg_s0    (rx_in[0]),
      .dbg_s1    (rx_in[1]),
      .fe_pins   (fe_pins),
      .misc_pins (misc_pins),
      .debug_bus (debug_bus)
   );

endmodule

`default_nettype wire

/* frontend_ctrl_props.sv */
/*
 * Concurrent checks on the front-end control top level
 */
`default_nettype none

module frontend_ctrl_props (
   input logic                                  bus_clk,
   input logic                                  pll_locked,
   input logic                                  bus_ready,
   input logic [frontend_pkg::NUM_CHANNELS-1:0] rx_stb,
   input logic [frontend_pkg::NUM_CHANNELS-1:0] rx_word_stb,
   input frontend_pkg::fe_pins_t                fe_pins [frontend_pkg::NUM_CHANNELS],
   input frontend_pkg::misc_pins_t              misc_pins,
   input logic                                  codec_arst,
   input logic                                  mimo,
   input logic [31:0]                           debug_bus
);
   timeunit 1ns;
   timeprecision 1ps;
   import frontend_pkg::*;

   int unsigned fail_cnt = 0;         // Read by the testbench at the end

   // ----------------------------------------------------------
   // Sample strobe and reset behavior
   // ----------------------------------------------------------
   rx_word_follows: assert property (@(posedge bus_clk)
      bus_ready && $past(bus_ready) |-> rx_word_stb == $past(rx_stb))
      else begin
         $error("rx_word_stb does not follow rx_stb by one cycle");
         fail_cnt++;
      end

   for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_fe_zero
      fe_zero: assert property (@(posedge bus_clk) !bus_ready |-> fe_pins[c] == '0)
         else begin
            $error("Front-end pins of channel %0d set while bus is down", c);
            fail_cnt++;
         end
   end

   // Misc pins, radio control, strobes and debug bus
   misc_zero: assert property (@(posedge bus_clk)
      !bus_ready |-> {misc_pins, codec_arst, mimo, rx_word_stb, debug_bus} == '0)
      else begin
         $error("Board outputs set while bus is down");
         fail_cnt++;
      end

   ready_needs_lock: assert property (@(posedge bus_clk) $rose(bus_ready) |-> pll_locked)
      else begin
         $error("bus_ready rose without PLL lock");
         fail_cnt++;
      end

endmodule

`default_nettype wire

/* tb_frontend_ctrl.sv */
/*
 * Testbench for the front-end control top level. Models the written
 * registers, checks pins, packed samples and the debug bus
 */
`default_nettype none

module tb_frontend_ctrl;
   timeunit 1ns;
   timeprecision 1ps;
   import frontend_pkg::*;

   logic                    bus_clk = 1'b0;
   logic                    reset_global;
   logic                    pll_locked;
   set_bus_t                set_in;
   logic [NUM_CHANNELS-1:0] run_rx;
   logic [NUM_CHANNELS-1:0] run_tx;
   logic [NUM_CHANNELS-1:0] rx_stb;
   iq_sample_t              rx_in [NUM_CHANNELS];
   logic                    bus_ready;
   fe_pins_t                fe_pins [NUM_CHANNELS];
   misc_pins_t              misc_pins;
   logic                    codec_arst;
   logic                    mimo;
   logic [WORD_W-1:0]       rx_word [NUM_CHANNELS];
   logic [NUM_CHANNELS-1:0] rx_word_stb;
   logic [31:0]             debug_bus;

   // Register model and expected streams
   logic [7:0]        atr_model [NUM_CHANNELS][4];
   logic [5:0]        misc_model;
   logic [1:0]        ctrl_model;
   logic [WORD_W-1:0] exp_words [NUM_CHANNELS][$];
   logic [31:0]       exp_dbg [$];
   logic [31:0]       dbg_last = '0;     // Last debug word captured
   logic              timed_out = 1'b0;
   int                errors = 0;
   int                tests_run = 0;
   int                err_mark = 0;

   always #4 bus_clk = ~bus_clk;         // 8 ns period

   frontend_ctrl_top frontend_ctrl_top_i (
      .bus_clk      (bus_clk),
      .reset_global (reset_global),
      .pll_locked   (pll_locked),
      .set_in       (set_in),
      .run_rx       (run_rx),
      .run_tx       (run_tx),
      .rx_stb       (rx_stb),
      .rx_in        (rx_in),
      .bus_ready    (bus_ready),
      .fe_pins      (fe_pins),
      .misc_pins    (misc_pins),
      .codec_arst   (codec_arst),
      .mimo         (mimo),
      .rx_word      (rx_word),
      .rx_word_stb  (rx_word_stb),
      .debug_bus    (debug_bus)
   );

   bind frontend_ctrl_top frontend_ctrl_props props_i (
      .bus_clk     (bus_clk),
      .pll_locked  (pll_locked),
      .bus_ready   (bus_ready),
      .rx_stb      (rx_stb),
      .rx_word_stb (rx_word_stb),
      .fe_pins     (fe_pins),
      .misc_pins   (misc_pins),
      .codec_arst  (codec_arst),
      .mimo        (mimo),
      .debug_bus   (debug_bus)
   );

   // ------------------------------------------------------------
   // Reference model
   // ------------------------------------------------------------
   // Radio state from the run flags, then that state's ATR word
   function automatic fe_pins_t expected_fe(input int ch, input logic rx, input logic tx);
      atr_state_e st;
      if (rx && tx) st = FULL_DUPLEX;
      else if (tx) st = TX_ONLY;
      else if (rx) st = RX_ONLY;
      else st = IDLE;
      return fe_pins_t'(atr_model[ch][st]);
   endfunction

   // I in 31:20, Q in 15:4, everything else zero
   function automatic logic [WORD_W-1:0] pack_word(input iq_sample_t s);
      logic [WORD_W-1:0] w;
      w        = '0;
      w[31:20] = s.i;
      w[15:4]  = s.q;
      return w;
   endfunction

   function automatic logic [31:0] debug_word(input iq_sample_t s0, input iq_sample_t s1);
      logic [31:0] w;
      w[31:24] = s1.i[11:4];             // Top byte of channel 1 I
      w[23:12] = s0.q;
      w[11:0]  = s0.i;
      return w;
   endfunction

   // ------------------------------------------------------------
   // Helpers
   // ------------------------------------------------------------
   task automatic step();
      @(posedge bus_clk);
      #1;                                // Drive just after the edge
   endtask

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else begin
         $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
         errors++;
      end
   endtask

   task automatic timeout_stop(input string what);
      $display("Timeout while waiting for %s", what);
      timed_out = 1'b1;
      wait (!timed_out);                 // Watchdog process ends the run
   endtask

   task automatic clear_model();
      for (int c = 0; c < NUM_CHANNELS; c++) begin
         for (int r = 0; r < 4; r++) atr_model[c][r] = '0;
      end
      misc_model = '0;
      ctrl_model = '0;
   endtask

   // One settings write, model follows only when the bus is up
   task automatic write_reg(input logic [3:0] target, input logic [3:0] sel,
                            input logic [31:0] data);
      set_in = '{stb: 1'b1, addr: {target, sel}, data: data};
      if (bus_ready === 1'b1) begin
         if (target == 4'h0 && sel == MISC_OUTS) misc_model = data[5:0];
         if (target == 4'h0 && sel == RADIO_CTRL) ctrl_model = data[1:0];
         if (target >= 4'h1 && target <= 4'(NUM_CHANNELS) && sel <= ATR_FDX) begin
            atr_model[target - 4'h1][sel[1:0]] = data[7:0];
         end
      end
      step();
      set_in.stb = 1'b0;
   endtask

   task automatic check_outputs();
      for (int c = 0; c < NUM_CHANNELS; c++) begin
         check_val($sformatf("fe_pins[%0d]", c), 32'(fe_pins[c]),
                   32'(expected_fe(c, run_rx[c], run_tx[c])));
      end
      check_val("misc_pins", 32'(misc_pins), 32'(misc_model));
      check_val("codec_arst", 32'(codec_arst), 32'(ctrl_model[1]));
      check_val("mimo", 32'(mimo), 32'(ctrl_model[0]));
   endtask

   task automatic check_zero();
      for (int c = 0; c < NUM_CHANNELS; c++) begin
         check_val($sformatf("fe_pins[%0d]", c), 32'(fe_pins[c]), 32'h0);
      end
      check_val("misc_pins", 32'(misc_pins), 32'h0);
      check_val("codec_arst", 32'(codec_arst), 32'h0);
      check_val("mimo", 32'(mimo), 32'h0);
      check_val("rx_word_stb", 32'(rx_word_stb), 32'h0);
      check_val("debug_bus", debug_bus, 32'h0);
   endtask

   // Poll bus_ready, optionally checking quiet outputs meanwhile
   task automatic wait_ready(input logic level, input int limit, input bit quiet,
                             input string what);
      int n;
      n = 0;
      while (bus_ready !== level && n < limit) begin
         if (quiet) check_zero();
         step();
         n++;
      end
      if (bus_ready !== level) timeout_stop(what);
   endtask

   task automatic write_all_atr();
      for (int c = 0; c < NUM_CHANNELS; c++) begin
         for (int r = 0; r < 4; r++) write_reg(4'(c + 1), 4'(r), $urandom());
      end
   endtask

   // Back-to-back samples on the channels in mask
   task automatic rx_burst(input int n, input logic [NUM_CHANNELS-1:0] mask);
      int k;
      k = 0;
      for (int b = 0; b < n; b++) begin
         for (int c = 0; c < NUM_CHANNELS; c++) begin
            rx_in[c].i = SAMPLE_W'($urandom());
            rx_in[c].q = SAMPLE_W'($urandom());
            if (mask[c]) exp_words[c].push_back(pack_word(rx_in[c]));
         end
         if (mask[0]) begin
            dbg_last = debug_word(rx_in[0], rx_in[1]);
            exp_dbg.push_back(dbg_last);
         end
         rx_stb = mask;
         step();
      end
      rx_stb = '0;
      while ((exp_words[0].size() != 0 || exp_words[1].size() != 0) && k < 10) begin
         step();
         k++;
      end
      if (exp_words[0].size() != 0 || exp_words[1].size() != 0) timeout_stop("rx words");
   endtask

   task automatic end_test(input string name);
      tests_run++;
      $display("Test %0d %s finished with %0d error(s)", tests_run, name, errors - err_mark);
      err_mark = errors;
   endtask

   // ------------------------------------------------------------
   // Comparing process for sample words and debug bus
   // ------------------------------------------------------------
   always @(negedge bus_clk) begin : compare_stream
      logic [31:0] exp_w;
      for (int c = 0; c < NUM_CHANNELS; c++) begin
         if (rx_word_stb[c] === 1'b1) begin
            assert (exp_words[c].size() != 0) else begin
               $display("Unexpected rx_word_stb on channel %0d", c);
               errors++;
            end
            if (exp_words[c].size() != 0) begin
               exp_w = exp_words[c].pop_front();
               check_val($sformatf("rx_word[%0d]", c), rx_word[c], exp_w);
            end
         end
      end
      if (rx_word_stb[0] === 1'b1 && exp_dbg.size() != 0) begin
         exp_w = exp_dbg.pop_front();
         check_val("debug_bus", debug_bus, exp_w);
      end
   end

   initial begin : watchdog
      wait (timed_out === 1'b1);
      $display("TB FAILED");
      $finish;
   end

   // ------------------------------------------------------------
   // Test sequence
   // ------------------------------------------------------------
   initial begin
      void'($urandom(32'hfbfe));
      reset_global = 1'b1;
      pll_locked   = 1'b1;
      set_in       = '0;
      run_rx       = '0;
      run_tx       = '0;
      rx_stb       = '0;
      for (int c = 0; c < NUM_CHANNELS; c++) rx_in[c] = '0;
      clear_model();
      repeat (10) step();
      reset_global = 1'b0;

      write_reg(4'h1, ATR_IDLE, 32'hff);  // Lost, bus still in hold-off
      wait_ready(1'b1, 200, 1'b1, "bus_ready after reset");
      check_outputs();
      end_test("hold-off and reset values");

      write_all_atr();
      for (int k = 0; k < 4; k++) begin
         run_rx[0] = k[0];
         run_tx[0] = k[1];
         run_rx[1] = ~k[0];              // Other channel walks the reverse order
         run_tx[1] = ~k[1];
         repeat (6) step();
         check_outputs();
      end
      end_test("ATR selection");

      repeat (4) begin
         write_reg(4'h0, MISC_OUTS, $urandom());
         write_reg(4'h0, RADIO_CTRL, $urandom());
         repeat (5) step();
         check_outputs();
      end
      write_reg(4'h0, ATR_TX, $urandom());        // ATR slot of global target
      write_reg(4'h1, MISC_OUTS, $urandom());     // Global slot of a channel
      write_reg(4'h2, 4'ha, $urandom());
      write_reg(4'(NUM_CHANNELS + 1 + $urandom_range(12, 0)), 4'($urandom_range(5, 0)),
                $urandom());
      repeat (5) step();
      check_outputs();
      end_test("global controls");

      rx_burst(24, 2'b11);
      end_test("sample packing");

      rx_burst(1, 2'b01);
      rx_burst(3, 2'b10);                // Channel 1 alone leaves debug alone
      check_val("debug_bus", debug_bus, dbg_last);
      end_test("debug bus");

      pll_locked = 1'b0;
      wait_ready(1'b0, 4, 1'b0, "bus_ready to fall after lock loss");
      clear_model();
      repeat (HOLDOFF_CYCLES + 8) begin  // Longer than a full hold-off without lock
         check_val("bus_ready", 32'(bus_ready), 32'h0);
         check_zero();
         step();
      end
      pll_locked = 1'b1;
      wait_ready(1'b1, 200, 1'b1, "bus_ready after lock returns");
      check_outputs();
      write_all_atr();
      write_reg(4'h0, MISC_OUTS, $urandom());
      write_reg(4'h0, RADIO_CTRL, $urandom());
      repeat (6) step();
      check_outputs();
      end_test("lock loss");

      errors += int'(frontend_ctrl_top_i.props_i.fail_cnt);
      $display("Tests run %0d, errors %0d", tests_run, errors);
      if (errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* compile.f */
frontend_pkg.sv
reset_holdoff.sv
settings_decoder.sv
fe_channel.sv
fe_pin_map.sv
frontend_ctrl_top.sv
frontend_ctrl_props.sv
tb_frontend_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and decide pass or fail from the log
rm -f sim.log &&
verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_frontend_ctrl -f compile.f &&
{ ./obj_dir/Vtb_frontend_ctrl +verilator+error+limit+100 > sim.log 2>&1; cat sim.log; } &&
grep -q "^TB PASSED$" sim.log && echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
